//--- hw/exec_pipe.sv
`default_nettype none
`timescale 1ns/100ps

`include "sched_defs.svh"

module exec_pipe
  import sched_pkg::*;
(
  input  wire                       i_clk,
  input  wire                       i_reset_n,
  input  wire                       i_pick_valid,
  input  wire entry_idx_t           i_pick_idx,
  input  wire rnid_t                i_rd_rnid,
  input  wire brmask_t              i_br_mask,
  wb_bcast_if.pipe                  bus,
  output logic                      o_issue_valid,
  output rnid_t                     o_issue_rd_rnid,
  output logic [`SCHED_ENTRIES-1:0] o_done
);

  localparam int LAST = `EXEC_LAT - 1;

  logic       r_valid [`EXEC_LAT];
  entry_idx_t r_idx   [`EXEC_LAT];
  rnid_t      r_rd    [`EXEC_LAT];
  brmask_t    r_mask  [`EXEC_LAT];
  logic       w_kill  [`EXEC_LAT];
  brmask_t    w_mask_in;
  logic       w_fire;

  // picked op may see a resolve in its pick cycle
  always_comb begin
    w_mask_in = i_br_mask;
    if (bus.br_update) begin
      w_mask_in[bus.br_tag] = 1'b0;
    end
  end

  always_comb begin
    for (int s = 0; s < `EXEC_LAT; s++) begin
      w_kill[s] = bus.br_update & bus.br_mispredict & r_mask[s][bus.br_tag];
    end
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int s = 0; s < `EXEC_LAT; s++) begin
        r_valid[s] <= 1'b0;
      end
    end else begin
      r_valid[0] <= i_pick_valid;
      for (int s = 1; s < `EXEC_LAT; s++) begin
        r_valid[s] <= r_valid[s-1] & ~w_kill[s-1];
      end
    end
  end

  always_ff @(posedge i_clk) begin
    r_idx[0]  <= i_pick_idx;
    r_rd[0]   <= i_rd_rnid;
    r_mask[0] <= w_mask_in;
    for (int s = 1; s < `EXEC_LAT; s++) begin
      r_idx[s]  <= r_idx[s-1];
      r_rd[s]   <= r_rd[s-1];
      r_mask[s] <= r_mask[s-1];
      if (bus.br_update) begin
        r_mask[s][bus.br_tag] <= 1'b0;
      end
    end
  end

  assign o_issue_valid   = r_valid[0];
  assign o_issue_rd_rnid = r_rd[0];

  // last stage, report done and wake consumers on port 0
  assign w_fire = r_valid[LAST] & ~w_kill[LAST];

  assign bus.wr_valid[0] = w_fire;
  assign bus.wr_rnid[0]  = r_rd[LAST];

  always_comb begin
    o_done = '0;
    o_done[r_idx[LAST]] = w_fire;
  end

endmodule

`default_nettype wire

//--- hw/issue_picker.sv
`default_nettype none
`timescale 1ns/100ps

`include "sched_defs.svh"

module issue_picker
  import sched_pkg::*;
(
  input  wire [`SCHED_ENTRIES-1:0]  i_entry_ready,
  input  wire entry_idx_t           i_head_idx,
  output logic                      o_pick_valid,
  output logic [`SCHED_ENTRIES-1:0] o_pick,
  output entry_idx_t                o_pick_idx
);

  // walk from the head, first ready entry is the oldest
  always_comb begin
    entry_idx_t scan_idx;
    o_pick_valid = 1'b0;
    o_pick_idx   = i_head_idx;
    for (int i = 0; i < `SCHED_ENTRIES; i++) begin
      scan_idx = i_head_idx + entry_idx_t'(i);
      if (!o_pick_valid && i_entry_ready[scan_idx]) begin
        o_pick_valid = 1'b1;
        o_pick_idx   = scan_idx;
      end
    end
  end

  always_comb begin
    o_pick = '0;
    o_pick[o_pick_idx] = o_pick_valid;
  end

  // nothing ready is skipped and nothing unready is chosen
  always_comb begin
    a_pick_onehot: assert final ($onehot0(o_pick) &&
                                 ((o_pick & ~i_entry_ready) == '0) &&
                                 (o_pick_valid == (|i_entry_ready)))
      else $error("issue_picker: bad pick vector");
  end

endmodule

`default_nettype wire

//--- hw/issue_sched.sv
`default_nettype none
`timescale 1ns/100ps

`include "sched_defs.svh"

module issue_sched
  import sched_pkg::*;
(
  input  wire          i_clk,
  input  wire          i_reset_n,
  input  wire          i_disp_valid,
  input  wire          i_disp_rs1_valid,
  input  wire          i_disp_rs1_ready,
  input  wire rnid_t   i_disp_rs1_rnid,
  input  wire          i_disp_rs2_valid,
  input  wire          i_disp_rs2_ready,
  input  wire rnid_t   i_disp_rs2_rnid,
  input  wire rnid_t   i_disp_rd_rnid,
  input  wire brmask_t i_disp_br_mask,
  input  wire          i_ext_wr_valid,
  input  wire rnid_t   i_ext_wr_rnid,
  input  wire          i_br_update,
  input  wire brtag_t  i_br_tag,
  input  wire          i_br_mispredict,
  output logic         o_disp_ready,
  output logic         o_issue_valid,
  output rnid_t        o_issue_rd_rnid,
  output logic         o_retire_valid,
  output rnid_t        o_retire_rd_rnid,
  output logic         o_retire_dead
);

  logic [`SCHED_ENTRIES-1:0] w_put;
  logic [`SCHED_ENTRIES-1:0] w_at_head;
  logic [`SCHED_ENTRIES-1:0] w_entry_valid;
  logic [`SCHED_ENTRIES-1:0] w_entry_ready;
  logic [`SCHED_ENTRIES-1:0] w_entry_finish;
  logic [`SCHED_ENTRIES-1:0] w_entry_dead;
  logic [`SCHED_ENTRIES-1:0] w_pick;
  logic [`SCHED_ENTRIES-1:0] w_done;
  rnid_t                     w_rd_rnid [`SCHED_ENTRIES];
  brmask_t                   w_br_mask [`SCHED_ENTRIES];
  entry_idx_t                w_head_idx;
  entry_idx_t                w_pick_idx;
  logic                      w_pick_valid;

  wb_bcast_if u_bus ();

  // external producer and branch unit feed the shared bus
  assign u_bus.wr_valid[1]   = i_ext_wr_valid;
  assign u_bus.wr_rnid[1]    = i_ext_wr_rnid;
  assign u_bus.br_update     = i_br_update;
  assign u_bus.br_tag        = i_br_tag;
  assign u_bus.br_mispredict = i_br_mispredict;

  sched_ctrl u_ctrl (
    .i_clk          (i_clk),
    .i_reset_n      (i_reset_n),
    .i_disp_valid   (i_disp_valid),
    .i_entry_finish (w_entry_finish),
    .o_disp_ready   (o_disp_ready),
    .o_put          (w_put),
    .o_at_head      (w_at_head),
    .o_head_idx     (w_head_idx)
  );

  for (genvar e = 0; e < `SCHED_ENTRIES; e++) begin : g_entry
    sched_entry u_entry (
      .i_clk          (i_clk),
      .i_reset_n      (i_reset_n),
      .i_put          (w_put[e]),
      .i_rs1_valid    (i_disp_rs1_valid),
      .i_rs1_ready    (i_disp_rs1_ready),
      .i_rs2_valid    (i_disp_rs2_valid),
      .i_rs2_ready    (i_disp_rs2_ready),
      .i_rs1_rnid     (i_disp_rs1_rnid),
      .i_rs2_rnid     (i_disp_rs2_rnid),
      .i_rd_rnid      (i_disp_rd_rnid),
      .i_br_mask      (i_disp_br_mask),
      .i_at_head      (w_at_head[e]),
      .i_entry_picked (w_pick[e]),
      .i_pipe_done    (w_done[e]),
      .bus            (u_bus),
      .o_entry_valid  (w_entry_valid[e]),
      .o_entry_ready  (w_entry_ready[e]),
      .o_entry_finish (w_entry_finish[e]),
      .o_entry_dead   (w_entry_dead[e]),
      .o_rd_rnid      (w_rd_rnid[e]),
      .o_br_mask      (w_br_mask[e])
    );
  end

  issue_picker u_picker (
    .i_entry_ready (w_entry_ready),
    .i_head_idx    (w_head_idx),
    .o_pick_valid  (w_pick_valid),
    .o_pick        (w_pick),
    .o_pick_idx    (w_pick_idx)
  );

  exec_pipe u_pipe (
    .i_clk           (i_clk),
    .i_reset_n       (i_reset_n),
    .i_pick_valid    (w_pick_valid),
    .i_pick_idx      (w_pick_idx),
    .i_rd_rnid       (w_rd_rnid[w_pick_idx]),
    .i_br_mask       (w_br_mask[w_pick_idx]),
    .bus             (u_bus),
    .o_issue_valid   (o_issue_valid),
    .o_issue_rd_rnid (o_issue_rd_rnid),
    .o_done          (w_done)
  );

  // retire strobe, one cycle after the head finishes
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_retire_valid <= 1'b0;
    end else begin
      o_retire_valid <= |w_entry_finish;
    end
  end

  always_ff @(posedge i_clk) begin
    o_retire_rd_rnid <= w_rd_rnid[w_head_idx];
    o_retire_dead    <= w_entry_dead[w_head_idx];
  end

  // tail pointer must only ever land on a free entry
  a_put_free: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (w_put & w_entry_valid) == '0)
    else $error("issue_sched: dispatch into an occupied entry");

endmodule

`default_nettype wire

//--- hw/sched_ctrl.sv
`default_nettype none
`timescale 1ns/100ps

`include "sched_defs.svh"

module sched_ctrl
  import sched_pkg::*;
(
  input  wire                       i_clk,
  input  wire                       i_reset_n,
  input  wire                       i_disp_valid,
  input  wire [`SCHED_ENTRIES-1:0]  i_entry_finish,
  output logic                      o_disp_ready,
  output logic [`SCHED_ENTRIES-1:0] o_put,
  output logic [`SCHED_ENTRIES-1:0] o_at_head,
  output entry_idx_t                o_head_idx
);

  localparam int CNT_W = $clog2(`SCHED_ENTRIES + 1);

  entry_idx_t       r_head;
  entry_idx_t       r_tail;
  logic [CNT_W-1:0] r_count;
  logic             w_disp_fire;
  logic             w_retire;

  assign o_disp_ready = (r_count < CNT_W'(`SCHED_ENTRIES));
  assign w_disp_fire  = i_disp_valid & o_disp_ready;

  // only the head entry can finish
  assign w_retire = |i_entry_finish;

  // steer the new op into the tail slot
  always_comb begin
    o_put = '0;
    o_put[r_tail] = w_disp_fire;
  end

  always_comb begin
    o_at_head = '0;
    o_at_head[r_head] = 1'b1;
  end

  assign o_head_idx = r_head;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_head  <= '0;
      r_tail  <= '0;
      r_count <= '0;
    end else begin
      if (w_disp_fire) begin
        r_tail <= r_tail + 1'b1;
      end
      if (w_retire) begin
        r_head <= r_head + 1'b1;
      end
      // dispatch and retire in the same cycle leave the count alone
      case ({w_disp_fire, w_retire})
        2'b10:   r_count <= r_count + 1'b1;
        2'b01:   r_count <= r_count - 1'b1;
        default: r_count <= r_count;
      endcase
    end
  end

  a_occupancy: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    r_count <= CNT_W'(`SCHED_ENTRIES))
    else $error("sched_ctrl: occupancy above entry count");

  // retire must stay in dispatch order
  a_finish_at_head: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (i_entry_finish & ~o_at_head) == '0)
    else $error("sched_ctrl: finish from an entry that is not the head");

endmodule

`default_nettype wire

//--- hw/sched_defs.svh
`ifndef SCHED_DEFS_SVH
`define SCHED_DEFS_SVH

// number of scheduler entries
`define SCHED_ENTRIES 4

// physical register tag width
`define RNID_W 6

// branches in flight, one mask bit each
`define BRTAG_NUM 4

// cycles from pick to write-back
`define EXEC_LAT 2

// write-back broadcast ports
`define WB_PORTS 2

`endif

//--- hw/sched_entry.sv
`default_nettype none
`timescale 1ns/100ps

`include "sched_defs.svh"

module sched_entry
  import sched_pkg::*;
(
  input  wire              i_clk,
  input  wire              i_reset_n,
  input  wire              i_put,
  input  wire              i_rs1_valid,
  input  wire              i_rs1_ready,
  input  wire              i_rs2_valid,
  input  wire              i_rs2_ready,
  input  wire rnid_t       i_rs1_rnid,
  input  wire rnid_t       i_rs2_rnid,
  input  wire rnid_t       i_rd_rnid,
  input  wire brmask_t     i_br_mask,
  input  wire              i_at_head,
  input  wire              i_entry_picked,
  input  wire              i_pipe_done,
  wb_bcast_if.entry        bus,
  output logic             o_entry_valid,
  output logic             o_entry_ready,
  output logic             o_entry_finish,
  output logic             o_entry_dead,
  output rnid_t            o_rd_rnid,
  output brmask_t          o_br_mask
);

  sched_state_t r_state;
  sched_state_t w_state_next;

  logic    r_rs1_valid;
  logic    r_rs2_valid;
  logic    r_rs1_ready;
  logic    r_rs2_ready;
  rnid_t   r_rs1_rnid;
  rnid_t   r_rs2_rnid;
  rnid_t   r_rd_rnid;
  brmask_t r_br_mask;

  rnid_t   w_rs1_rnid;
  rnid_t   w_rs2_rnid;
  logic    w_rs1_hit;
  logic    w_rs2_hit;
  logic    w_rs1_valid_next;
  logic    w_rs2_valid_next;
  logic    w_rs1_ready_next;
  logic    w_rs2_ready_next;
  brmask_t w_mask_src;
  brmask_t w_mask_next;
  logic    w_br_flush;
  logic    w_put_flush;

  // on a put the incoming tags are compared, not the stale ones
  assign w_rs1_rnid = i_put ? i_rs1_rnid : r_rs1_rnid;
  assign w_rs2_rnid = i_put ? i_rs2_rnid : r_rs2_rnid;

  always_comb begin
    w_rs1_hit = 1'b0;
    w_rs2_hit = 1'b0;
    for (int p = 0; p < `WB_PORTS; p++) begin
      w_rs1_hit |= bus.wr_valid[p] & (bus.wr_rnid[p] == w_rs1_rnid);
      w_rs2_hit |= bus.wr_valid[p] & (bus.wr_rnid[p] == w_rs2_rnid);
    end
  end

  assign w_rs1_valid_next = i_put ? i_rs1_valid : r_rs1_valid;
  assign w_rs2_valid_next = i_put ? i_rs2_valid : r_rs2_valid;
  assign w_rs1_ready_next = (i_put ? i_rs1_ready : r_rs1_ready) | w_rs1_hit;
  assign w_rs2_ready_next = (i_put ? i_rs2_ready : r_rs2_ready) | w_rs2_hit;

  // resolved branches drop out of the mask
  assign w_mask_src = i_put ? i_br_mask : r_br_mask;

  always_comb begin
    w_mask_next = w_mask_src;
    if (bus.br_update) begin
      w_mask_next[bus.br_tag] = 1'b0;
    end
  end

  assign w_br_flush  = bus.br_update & bus.br_mispredict & r_br_mask[bus.br_tag] &
                       o_entry_valid;
  assign w_put_flush = bus.br_update & bus.br_mispredict & i_br_mask[bus.br_tag];

  always_comb begin
    w_state_next = r_state;
    case (r_state)
      INIT: begin
        if (i_put) begin
          w_state_next = w_put_flush ? DEAD : WAIT;
        end
      end
      WAIT: begin
        if (w_br_flush) begin
          w_state_next = DEAD;
        end else if (i_entry_picked) begin
          w_state_next = ISSUED;
        end
      end
      ISSUED: begin
        if (w_br_flush) begin
          w_state_next = DEAD;
        end else if (i_pipe_done) begin
          w_state_next = DONE;
        end
      end
      DONE: begin
        w_state_next = w_br_flush ? DEAD : WAIT_COMPLETE;
      end
      WAIT_COMPLETE: begin
        // a kill at the finish cycle still reports dead
        if (o_entry_finish) begin
          w_state_next = INIT;
        end else if (w_br_flush) begin
          w_state_next = DEAD;
        end
      end
      DEAD: begin
        if (o_entry_finish) begin
          w_state_next = INIT;
        end
      end
      default: w_state_next = INIT;
    endcase
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state     <= INIT;
      r_rs1_valid <= 1'b0;
      r_rs2_valid <= 1'b0;
      r_rs1_ready <= 1'b0;
      r_rs2_ready <= 1'b0;
    end else begin
      r_state     <= w_state_next;
      r_rs1_valid <= w_rs1_valid_next;
      r_rs2_valid <= w_rs2_valid_next;
      r_rs1_ready <= w_rs1_ready_next;
      r_rs2_ready <= w_rs2_ready_next;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_put) begin
      r_rs1_rnid <= i_rs1_rnid;
      r_rs2_rnid <= i_rs2_rnid;
      r_rd_rnid  <= i_rd_rnid;
    end
    r_br_mask <= w_mask_next;
  end

  assign o_entry_valid = (r_state != INIT);

  // wakeup bypass lets a same-cycle broadcast make the entry pickable
  assign o_entry_ready = (r_state == WAIT) & ~w_br_flush &
                         (~r_rs1_valid | w_rs1_ready_next) &
                         (~r_rs2_valid | w_rs2_ready_next);

  assign o_entry_finish = i_at_head & ((r_state == WAIT_COMPLETE) | (r_state == DEAD));
  assign o_entry_dead   = (r_state == DEAD) | w_br_flush;
  assign o_rd_rnid      = r_rd_rnid;
  assign o_br_mask      = r_br_mask;

  a_pick_ready: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_entry_picked |-> o_entry_ready)
    else $error("sched_entry: picked while not ready");

endmodule

`default_nettype wire

//--- hw/sched_pkg.sv
`default_nettype none

`include "sched_defs.svh"

package sched_pkg;

  // physical register tag
  typedef logic [`RNID_W-1:0] rnid_t;

  // one bit per outstanding branch
  typedef logic [`BRTAG_NUM-1:0] brmask_t;

  // index of a single branch
  typedef logic [$clog2(`BRTAG_NUM)-1:0] brtag_t;

  // scheduler entry index
  typedef logic [$clog2(`SCHED_ENTRIES)-1:0] entry_idx_t;

  // entry life cycle
  typedef enum logic [2:0] {
    INIT,
    WAIT,
    ISSUED,
    DONE,
    WAIT_COMPLETE,
    DEAD
  } sched_state_t;

endpackage

`default_nettype wire

//--- hw/wb_bcast_if.sv
`default_nettype none
`timescale 1ns/100ps

`include "sched_defs.svh"

interface wb_bcast_if
  import sched_pkg::*;
();

  // port 0 is the local pipe, port 1 an external producer
  logic   wr_valid [`WB_PORTS];
  rnid_t  wr_rnid  [`WB_PORTS];

  // branch resolve, clears br_tag in every mask
  logic   br_update;
  brtag_t br_tag;
  logic   br_mispredict;

  modport pipe (
    output wr_valid,
    output wr_rnid,
    input  br_update,
    input  br_tag,
    input  br_mispredict
  );

  modport entry (
    input wr_valid,
    input wr_rnid,
    input br_update,
    input br_tag,
    input br_mispredict
  );

endinterface

`default_nettype wire

//--- issue_sched.f
+incdir+hw
hw/sched_pkg.sv
hw/wb_bcast_if.sv
hw/sched_ctrl.sv
hw/sched_entry.sv
hw/issue_picker.sv
hw/exec_pipe.sv
hw/issue_sched.sv
test/tb_issue_sched.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f issue_sched.f \
  --top-module tb_issue_sched \
  --Mdir obj_dir -o sim_issue_sched

./obj_dir/sim_issue_sched

//--- test/tb_issue_sched.sv
`default_nettype none
`timescale 1ns/100ps

`include "sched_defs.svh"

module tb_issue_sched
  import sched_pkg::*;
();

  localparam int NTAGS       = 1 << `RNID_W;
  localparam int NEVER       = 2147483647;
  localparam int TARGET      = 300;
  localparam int MAX_CYCLES  = 20000;
  localparam int STALL_LIMIT = 500;
  localparam int POOL_DEPTH  = 6;

  logic    i_clk = 1'b0;
  logic    i_reset_n;
  logic    i_disp_valid;
  logic    i_disp_rs1_valid;
  logic    i_disp_rs1_ready;
  rnid_t   i_disp_rs1_rnid;
  logic    i_disp_rs2_valid;
  logic    i_disp_rs2_ready;
  rnid_t   i_disp_rs2_rnid;
  rnid_t   i_disp_rd_rnid;
  brmask_t i_disp_br_mask;
  logic    i_ext_wr_valid;
  rnid_t   i_ext_wr_rnid;
  logic    i_br_update;
  brtag_t  i_br_tag;
  logic    i_br_mispredict;
  logic    o_disp_ready;
  logic    o_issue_valid;
  rnid_t   o_issue_rd_rnid;
  logic    o_retire_valid;
  rnid_t   o_retire_rd_rnid;
  logic    o_retire_dead;

  // per-op reference records indexed by destination tag
  rnid_t   rob_q [$];
  rnid_t   pool [$];
  logic    in_q [NTAGS];
  logic    op_rs1_v [NTAGS];
  logic    op_rs1_rdy [NTAGS];
  rnid_t   op_rs1 [NTAGS];
  logic    op_rs2_v [NTAGS];
  logic    op_rs2_rdy [NTAGS];
  rnid_t   op_rs2 [NTAGS];
  brmask_t op_mask [NTAGS];
  logic    op_dead [NTAGS];
  int      op_kill_cyc [NTAGS];
  int      op_issue_cnt [NTAGS];
  int      op_issue_cyc [NTAGS];
  int      wr_cyc [NTAGS];

  brmask_t out_br;
  rnid_t   next_rd;
  int      cyc;
  int      retire_cnt;
  int      idle_cycles;
  int      cycles;

  // expectations for the cycle just sampled at the falling edge
  logic    exp_disp_ready = 1'b1;
  logic    retire_known = 1'b1;
  rnid_t   exp_retire_rd;
  logic    exp_retire_dead;
  logic    retire_issue_ok = 1'b1;
  logic    issue_once_ok = 1'b1;
  logic    issue_live_ok = 1'b1;
  logic    issue_src_ok = 1'b1;

  issue_sched u_issue_sched (
    .i_clk            (i_clk),
    .i_reset_n        (i_reset_n),
    .i_disp_valid     (i_disp_valid),
    .i_disp_rs1_valid (i_disp_rs1_valid),
    .i_disp_rs1_ready (i_disp_rs1_ready),
    .i_disp_rs1_rnid  (i_disp_rs1_rnid),
    .i_disp_rs2_valid (i_disp_rs2_valid),
    .i_disp_rs2_ready (i_disp_rs2_ready),
    .i_disp_rs2_rnid  (i_disp_rs2_rnid),
    .i_disp_rd_rnid   (i_disp_rd_rnid),
    .i_disp_br_mask   (i_disp_br_mask),
    .i_ext_wr_valid   (i_ext_wr_valid),
    .i_ext_wr_rnid    (i_ext_wr_rnid),
    .i_br_update      (i_br_update),
    .i_br_tag         (i_br_tag),
    .i_br_mispredict  (i_br_mispredict),
    .o_disp_ready     (o_disp_ready),
    .o_issue_valid    (o_issue_valid),
    .o_issue_rd_rnid  (o_issue_rd_rnid),
    .o_retire_valid   (o_retire_valid),
    .o_retire_rd_rnid (o_retire_rd_rnid),
    .o_retire_dead    (o_retire_dead)
  );

  always #4 i_clk = ~i_clk;

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("=== FAIL ===");
    $fatal(1);
  endtask

  // source operand already produced by the pick cycle
  function automatic logic src_ready(input logic v, input logic rdy, input rnid_t tag);
    return !v || rdy || (wr_cyc[tag] <= cyc - 1);
  endfunction

  task automatic pick_source(output logic v, output logic rdy, output rnid_t tag);
    int r;
    r = $urandom % 4;
    if (r == 0) begin
      v   = 1'b0;
      rdy = 1'b0;
      tag = rnid_t'($urandom);
    end else if (r == 1 || pool.size() == 0) begin
      v   = 1'b1;
      rdy = 1'b1;
      tag = rnid_t'($urandom);
    end else begin
      v   = 1'b1;
      tag = pool[$urandom % pool.size()];
      rdy = (wr_cyc[tag] != NEVER);
    end
  endtask

  // killed producers must never feed a later consumer
  task automatic drop_killed(input int t);
    rnid_t tag;
    foreach (rob_q[i]) begin
      tag = rob_q[i];
      if (op_mask[tag][t]) begin
        for (int j = pool.size() - 1; j >= 0; j--) begin
          if (pool[j] == tag) begin
            pool.delete(j);
          end
        end
      end
    end
  endtask

  task automatic drive_cycle();
    int      t;
    int      start;
    logic    misp;
    logic    v1;
    logic    r1;
    logic    v2;
    logic    r2;
    rnid_t   s1;
    rnid_t   s2;
    brmask_t disp_mask;
    t = -1;
    if (out_br != '0 && ($urandom % 8) == 0) begin
      start = $urandom % `BRTAG_NUM;
      for (int i = 0; i < `BRTAG_NUM; i++) begin
        if (t < 0 && out_br[(start + i) % `BRTAG_NUM]) begin
          t = (start + i) % `BRTAG_NUM;
        end
      end
    end
    if (t >= 0) begin
      misp = (($urandom % 3) == 0);
      if (misp) begin
        drop_killed(t);
      end
      // the op dispatched with the resolve still carries the bit
      disp_mask = out_br;
      out_br[t] = 1'b0;
      i_br_update     <= 1'b1;
      i_br_tag        <= brtag_t'(t);
      i_br_mispredict <= misp;
    end else begin
      i_br_update     <= 1'b0;
      i_br_mispredict <= 1'b0;
      // new branch goes into the masks of later ops
      if (($urandom % 6) == 0 && out_br != '1) begin
        for (int i = `BRTAG_NUM - 1; i >= 0; i--) begin
          if (!out_br[i]) begin
            t = i;
          end
        end
        out_br[t] = 1'b1;
      end
      disp_mask = out_br;
    end
    pick_source(v1, r1, s1);
    pick_source(v2, r2, s2);
    i_disp_valid     <= (($urandom % 4) != 0);
    i_disp_rs1_valid <= v1;
    i_disp_rs1_ready <= r1;
    i_disp_rs1_rnid  <= s1;
    i_disp_rs2_valid <= v2;
    i_disp_rs2_ready <= r2;
    i_disp_rs2_rnid  <= s2;
    i_disp_rd_rnid   <= next_rd;
    i_disp_br_mask   <= disp_mask;
    i_ext_wr_valid   <= (($urandom % 4) == 0);
    i_ext_wr_rnid    <= rnid_t'($urandom);
  endtask

  task automatic update_model();
    rnid_t tag;
    int    qn;
    logic  fire;
    logic  put_kill;
    cyc++;
    qn = rob_q.size() - (o_retire_valid ? 1 : 0);
    exp_disp_ready = (qn < `SCHED_ENTRIES);
    fire = i_disp_valid && exp_disp_ready;
    put_kill = i_br_update && i_br_mispredict && i_disp_br_mask[i_br_tag];
    if (o_retire_valid) begin
      retire_cnt++;
      idle_cycles = 0;
      if (rob_q.size() == 0) begin
        retire_known = 1'b0;
      end else begin
        tag = rob_q.pop_front();
        in_q[tag]       = 1'b0;
        retire_known    = 1'b1;
        exp_retire_rd   = tag;
        exp_retire_dead = op_dead[tag];
        retire_issue_ok = op_dead[tag] || (op_issue_cnt[tag] == 1);
      end
    end else begin
      idle_cycles++;
    end
    if (o_issue_valid) begin
      tag = o_issue_rd_rnid;
      issue_once_ok = in_q[tag] && (op_issue_cnt[tag] == 0);
      issue_live_ok = !(op_dead[tag] && op_kill_cyc[tag] < cyc);
      issue_src_ok  = src_ready(op_rs1_v[tag], op_rs1_rdy[tag], op_rs1[tag]) &&
                      src_ready(op_rs2_v[tag], op_rs2_rdy[tag], op_rs2[tag]);
      op_issue_cnt[tag]++;
      op_issue_cyc[tag] = cyc;
    end
    if (fire) begin
      tag = i_disp_rd_rnid;
      rob_q.push_back(tag);
      in_q[tag]         = 1'b1;
      op_rs1_v[tag]     = i_disp_rs1_valid;
      op_rs1_rdy[tag]   = i_disp_rs1_ready;
      op_rs1[tag]       = i_disp_rs1_rnid;
      op_rs2_v[tag]     = i_disp_rs2_valid;
      op_rs2_rdy[tag]   = i_disp_rs2_ready;
      op_rs2[tag]       = i_disp_rs2_rnid;
      op_mask[tag]      = i_disp_br_mask;
      op_dead[tag]      = 1'b0;
      op_issue_cnt[tag] = 0;
      op_issue_cyc[tag] = -1;
      wr_cyc[tag]       = NEVER;
      // an op killed on its way in never produces a value
      if (!put_kill) begin
        pool.push_back(tag);
        if (pool.size() > POOL_DEPTH) begin
          void'(pool.pop_front());
        end
      end
      next_rd = next_rd + 1'b1;
    end
    // a mispredict kills every queued holder of the bit including this dispatch
    if (i_br_update) begin
      foreach (rob_q[i]) begin
        tag = rob_q[i];
        if (i_br_mispredict && op_mask[tag][i_br_tag] && !op_dead[tag]) begin
          op_dead[tag]     = 1'b1;
          op_kill_cyc[tag] = cyc;
        end
        op_mask[tag][i_br_tag] = 1'b0;
      end
    end
    foreach (rob_q[i]) begin
      tag = rob_q[i];
      if (op_issue_cyc[tag] == cyc - (`EXEC_LAT - 1) && !op_dead[tag] &&
          wr_cyc[tag] == NEVER) begin
        wr_cyc[tag] = cyc;
      end
    end
    if (i_ext_wr_valid && wr_cyc[i_ext_wr_rnid] == NEVER) begin
      wr_cyc[i_ext_wr_rnid] = cyc;
    end
  endtask

  always @(negedge i_clk) begin
    if (i_reset_n) begin
      update_model();
    end
  end

  a_reset_state: assert property (@(posedge i_clk)
    $rose(i_reset_n) |-> (!o_issue_valid && !o_retire_valid && o_disp_ready))
    else fail_run($sformatf("** Error @ %0t: outputs not idle after reset", $time));

  a_disp_ready: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_disp_ready == exp_disp_ready)
    else fail_run($sformatf("** Error @ %0t: disp_ready %0b, expected %0b",
                            $time, $sampled(o_disp_ready), exp_disp_ready));

  // no issue before the producer has written back
  a_issue_src: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_issue_valid |-> issue_src_ok)
    else fail_run($sformatf("** Error @ %0t: tag %0d issued with a source not ready",
                            $time, $sampled(o_issue_rd_rnid)));

  a_issue_live: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_issue_valid |-> issue_live_ok)
    else fail_run($sformatf("** Error @ %0t: tag %0d issued after its flush",
                            $time, $sampled(o_issue_rd_rnid)));

  a_issue_once: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_issue_valid |-> issue_once_ok)
    else fail_run($sformatf("** Error @ %0t: tag %0d issued twice or not queued",
                            $time, $sampled(o_issue_rd_rnid)));

  a_retire_order: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_retire_valid |-> (retire_known && o_retire_rd_rnid == exp_retire_rd))
    else fail_run($sformatf("** Error @ %0t: retired tag %0d, expected %0d",
                            $time, $sampled(o_retire_rd_rnid), exp_retire_rd));

  a_retire_dead: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_retire_valid |-> (o_retire_dead == exp_retire_dead))
    else fail_run($sformatf("** Error @ %0t: tag %0d retired dead=%0b, expected %0b",
                            $time, exp_retire_rd, $sampled(o_retire_dead),
                            exp_retire_dead));

  a_retire_issued: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_retire_valid |-> retire_issue_ok)
    else fail_run($sformatf("** Error @ %0t: live tag %0d retired without one issue",
                            $time, exp_retire_rd));

  initial begin
    void'($urandom(32'h9988));
    i_reset_n        = 1'b0;
    i_disp_valid     = 1'b0;
    i_disp_rs1_valid = 1'b0;
    i_disp_rs1_ready = 1'b0;
    i_disp_rs1_rnid  = '0;
    i_disp_rs2_valid = 1'b0;
    i_disp_rs2_ready = 1'b0;
    i_disp_rs2_rnid  = '0;
    i_disp_rd_rnid   = '0;
    i_disp_br_mask   = '0;
    i_ext_wr_valid   = 1'b0;
    i_ext_wr_rnid    = '0;
    i_br_update      = 1'b0;
    i_br_tag         = '0;
    i_br_mispredict  = 1'b0;
    out_br      = '0;
    next_rd     = rnid_t'(1);
    cyc         = 0;
    retire_cnt  = 0;
    idle_cycles = 0;
    cycles      = 0;
    for (int i = 0; i < NTAGS; i++) begin
      in_q[i]   = 1'b0;
      op_dead[i] = 1'b0;
      wr_cyc[i] = NEVER;
    end
    repeat (2) @(posedge i_clk);
    i_reset_n <= 1'b1;
    while (retire_cnt < TARGET && cycles < MAX_CYCLES && idle_cycles < STALL_LIMIT) begin
      @(posedge i_clk);
      drive_cycle();
      cycles++;
    end
    if (retire_cnt >= TARGET) begin
      $display("=== PASS ===");
      $finish;
    end else begin
      fail_run($sformatf("timeout: only %0d of %0d ops retired, no retire for %0d cycles",
                         retire_cnt, TARGET, idle_cycles));
    end
  end

endmodule

`default_nettype wire
